/* hdl/snes_loader_pkg.sv */
// Cartridge loader shared definitions
package snes_loader_pkg;

	// ==============================
	// Widths
	// ==============================
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;
	localparam int MASK_W       = 24;
	localparam int LBA_W        = 32;

	// Download index codes
	localparam logic [5:0] IDX_CART  = 6'd0;
	localparam logic [7:0] IDX_CHEAT = 8'hFF;

	// ==============================
	// Header locations
	// ==============================
	localparam logic [IOCTL_ADDR_W-1:0] HEADER_SKIP  = 25'h000200;
	localparam logic [IOCTL_ADDR_W-1:0] LOROM_INFO   = 25'h007FD6;
	localparam logic [IOCTL_ADDR_W-1:0] HIROM_INFO   = 25'h00FFD6;
	localparam logic [IOCTL_ADDR_W-1:0] EXHIROM_INFO = 25'h40FFD6;

	// Menu header-mode codes
	localparam logic [2:0] HDR_AUTO    = 3'd0;
	localparam logic [2:0] HDR_NONE    = 3'd1;
	localparam logic [2:0] HDR_LOROM   = 3'd2;
	localparam logic [2:0] HDR_HIROM   = 3'd3;
	localparam logic [2:0] HDR_EXHIROM = 3'd4;

	// Cheat code, written as halfwords and read as fields
	typedef union packed {
		logic [7:0][15:0] half;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
	} cheat_code_u;

endpackage

/* hdl/load_control.sv */
// Download decode and load control
`timescale 1ns/1ps

module load_control (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               ioctl_download,
	input  logic [7:0]                         ioctl_index,
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic [63:0]                        img_size,
	input  logic [snes_loader_pkg::MASK_W-1:0] ram_mask,
	input  logic                               clearing,
	input  logic                               bk_loading,
	output logic                               cart_dl,
	output logic                               cheat_dl,
	output logic                               clear_start,
	output logic                               autoload_start,
	output logic                               bk_enable,
	output logic                               system_reset
);

	logic old_cart_dl;

	// Index decode
	assign cart_dl  = ioctl_download && (ioctl_index[5:0] == snes_loader_pkg::IDX_CART);
	assign cheat_dl = ioctl_download && (ioctl_index == snes_loader_pkg::IDX_CHEAT);

	// ==============================
	// Download edges
	// ==============================
	assign clear_start = cart_dl && !old_cart_dl;

	// Backup image is pulled in once the cartridge is fully loaded
	assign autoload_start = old_cart_dl && !cart_dl && (|img_size) && bk_enable;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart_dl <= 1'b0;
			bk_enable   <= 1'b0;
		end else begin
			old_cart_dl <= cart_dl;
			if (clear_start) begin
				bk_enable <= 1'b0;
			end
			// Save file is mounted before the download ends
			if (cart_dl && img_mounted && !img_readonly) begin
				bk_enable <= |ram_mask;
			end
		end
	end

	// Machine held in reset while any loader action runs
	always_ff @(posedge clk_sys) begin
		system_reset <= reset || cart_dl || clearing || bk_loading;
	end

endmodule

/* hdl/rom_header_parser.sv */
// ROM header detection
`timescale 1ns/1ps

module rom_header_parser (
	input  logic                                     clk_sys,
	input  logic                                     reset,
	input  logic                                     cart_dl,
	input  logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [snes_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                     ioctl_wr,
	input  logic [2:0]                               header_mode,
	input  logic [1:0]                               region_override,
	output logic [7:0]                               rom_type,
	output logic [snes_loader_pkg::MASK_W-1:0]       rom_mask,
	output logic [snes_loader_pkg::MASK_W-1:0]       ram_mask,
	output logic                                     pal
);

	logic [3:0]                               rom_size;
	logic [3:0]                               ram_size;
	logic [3:0]                               rom_size_nxt;
	logic [3:0]                               ram_size_nxt;
	logic                                     header_region;
	logic                                     sized_mode;
	logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] info_addr;
	logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] rom_size_addr;
	logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] ram_size_addr;

	function automatic logic [snes_loader_pkg::MASK_W-1:0] size_to_mask(input logic [3:0] size);
		size_to_mask = (snes_loader_pkg::MASK_W'(1024) << size) - 1'b1;
	endfunction

	// Info block location for the forced mapper modes
	always_comb begin
		sized_mode = 1'b1;
		case (header_mode)
			snes_loader_pkg::HDR_LOROM:   info_addr = snes_loader_pkg::LOROM_INFO;
			snes_loader_pkg::HDR_HIROM:   info_addr = snes_loader_pkg::HIROM_INFO;
			snes_loader_pkg::HDR_EXHIROM: info_addr = snes_loader_pkg::EXHIROM_INFO;
			default: begin
				info_addr  = '0;
				sized_mode = 1'b0;
			end
		endcase
	end

	assign rom_size_addr = info_addr + snes_loader_pkg::HEADER_SKIP;
	assign ram_size_addr = info_addr + snes_loader_pkg::HEADER_SKIP + 2'd2;

	// ==============================
	// Size capture
	// ==============================
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (ioctl_addr == '0) begin
			rom_size_nxt = 4'hC;
			ram_size_nxt = 4'h0;
			// Auto mode takes both sizes from the first byte
			if (header_mode == snes_loader_pkg::HDR_AUTO && ioctl_dout[7:0] != 8'h00) begin
				{ram_size_nxt, rom_size_nxt} = ioctl_dout[7:0];
			end
		end
		if (sized_mode && ioctl_addr == rom_size_addr) begin
			rom_size_nxt = ioctl_dout[11:8];
		end
		if (sized_mode && ioctl_addr == ram_size_addr) begin
			ram_size_nxt = ioctl_dout[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size      <= 4'hC;
			ram_size      <= 4'h0;
			rom_type      <= 8'h00;
			rom_mask      <= '0;
			ram_mask      <= '0;
			header_region <= 1'b0;
			pal           <= 1'b0;
		end else if (cart_dl) begin
			if (ioctl_wr) begin
				rom_size <= rom_size_nxt;
				ram_size <= ram_size_nxt;
				rom_mask <= size_to_mask(rom_size_nxt);
				ram_mask <= (ram_size_nxt != 4'h0) ? size_to_mask(ram_size_nxt) : '0;
				if (ioctl_addr == '0) begin
					case (header_mode)
						snes_loader_pkg::HDR_NONE:    rom_type <= 8'd0;
						snes_loader_pkg::HDR_LOROM:   rom_type <= 8'd0;
						snes_loader_pkg::HDR_HIROM:   rom_type <= 8'd1;
						snes_loader_pkg::HDR_EXHIROM: rom_type <= 8'd2;
						default:                      rom_type <= ioctl_dout[15:8];
					endcase
				end
				if (ioctl_addr == 2) begin
					header_region <= ioctl_dout[8];
				end
			end
		end else begin
			// Override bit 1 selects PAL when forced
			pal <= (region_override == 2'd0) ? header_region : region_override[1];
		end
	end

endmodule

/* hdl/cheat_code_assembler.sv */
// Cheat code assembly
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                                     clk_sys,
	input  logic                                     reset,
	input  logic                                     cheat_dl,
	input  logic                                     cart_dl,
	input  logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [snes_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                     ioctl_wr,
	output snes_loader_pkg::cheat_code_u             cheat_code,
	output logic                                     cheat_strobe,
	output logic                                     cheat_reset
);

	logic       code_wr;
	logic [2:0] half_sel;

	assign code_wr = cheat_dl && ioctl_wr;

	// Low word of each field lands below its high word
	assign half_sel = {~ioctl_addr[3:2], ioctl_addr[1]};

	assign cheat_reset = (code_wr && ioctl_addr == '0) || cart_dl;

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			cheat_code.half[half_sel] <= ioctl_dout;
		end
	end

	// Replace top word completes the code
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_strobe <= 1'b0;
		end else begin
			cheat_strobe <= code_wr && (ioctl_addr[3:0] == 4'd14);
		end
	end

endmodule

/* hdl/wram_clear_engine.sv */
// Work RAM power-on fill
`timescale 1ns/1ps

module wram_clear_engine #(
	parameter int WRAM_AW = 17
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               clear_start,
	input  logic [1:0]         wram_init_mode,
	output logic [WRAM_AW-1:0] wram_fill_addr,
	output logic [7:0]         wram_fill_data,
	output logic               wram_fill_wr,
	output logic               clearing
);

	// Pattern taps reach bit 9 even for small RAMs
	localparam int EXT_W = (WRAM_AW > 10) ? WRAM_AW : 10;

	logic [EXT_W-1:0] addr_ext;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clearing       <= 1'b0;
			wram_fill_addr <= '0;
		end else if (clear_start) begin
			clearing       <= 1'b1;
			wram_fill_addr <= '0;
		end else if (clearing) begin
			wram_fill_addr <= wram_fill_addr + 1'b1;
			if (&wram_fill_addr) begin
				clearing <= 1'b0;
			end
		end
	end

	assign wram_fill_wr = clearing;
	assign addr_ext     = EXT_W'(wram_fill_addr);

	// Fill pattern by console revision
	always_comb begin
		case (wram_init_mode)
			2'd0:    wram_fill_data = (addr_ext[8] ^ addr_ext[2]) ? 8'h66 : 8'h99;
			2'd1:    wram_fill_data = (addr_ext[9] ^ addr_ext[0]) ? 8'hFF : 8'h00;
			2'd2:    wram_fill_data = 8'h55;
			default: wram_fill_data = 8'hFF;
		endcase
	end

endmodule

/* hdl/backup_sequencer.sv */
// Backup RAM sector sequencer
`timescale 1ns/1ps

module backup_sequencer (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               bk_enable,
	input  logic                               bk_load_req,
	input  logic                               bk_save_req,
	input  logic                               autoload_start,
	input  logic [snes_loader_pkg::MASK_W-1:0] ram_mask,
	input  logic                               sd_ack,
	output logic [snes_loader_pkg::LBA_W-1:0]  sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic                               bk_busy,
	output logic                               bk_loading
);

	logic                              load_req;
	logic                              save_req;
	logic                              old_load;
	logic                              old_save;
	logic                              old_ack;
	logic                              load_edge;
	logic                              save_edge;
	logic [snes_loader_pkg::LBA_W-1:0] last_lba;

	// Requests only count while a writable image is mounted
	assign load_req  = bk_load_req && bk_enable;
	assign save_req  = bk_save_req && bk_enable;
	assign load_edge = load_req && !old_load;
	assign save_edge = save_req && !old_save;

	// One sector is 512 bytes
	assign last_lba = snes_loader_pkg::LBA_W'(ram_mask[snes_loader_pkg::MASK_W-1:9]);

	// ==============================
	// Sector walk
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_ack  <= sd_ack;

			// Host took the request
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (autoload_start) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end else if (load_edge || save_edge) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_edge;
					sd_lba     <= '0;
					sd_rd      <= load_edge;
					sd_wr      <= !load_edge;
				end
			end else if (old_ack && !sd_ack) begin
				// Sector done, move on or stop
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

/* hdl/snes_loader_top.sv */
// Cartridge loader top level
`timescale 1ns/1ps

module snes_loader_top #(
	parameter int WRAM_AW = 17
) (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    ioctl_download,
	input  logic [7:0]                              ioctl_index,
	input  logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [snes_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	input  logic                                    ioctl_wr,
	input  logic [2:0]                              header_mode,
	input  logic [1:0]                              region_override,
	input  logic [1:0]                              wram_init_mode,
	input  logic                                    img_mounted,
	input  logic                                    img_readonly,
	input  logic [63:0]                             img_size,
	input  logic                                    bk_load_req,
	input  logic                                    bk_save_req,
	input  logic                                    sd_ack,
	output logic [7:0]                              rom_type,
	output logic [snes_loader_pkg::MASK_W-1:0]      rom_mask,
	output logic [snes_loader_pkg::MASK_W-1:0]      ram_mask,
	output logic                                    pal,
	output snes_loader_pkg::cheat_code_u            cheat_code,
	output logic                                    cheat_strobe,
	output logic                                    cheat_reset,
	output logic [WRAM_AW-1:0]                      wram_fill_addr,
	output logic [7:0]                              wram_fill_data,
	output logic                                    wram_fill_wr,
	output logic [snes_loader_pkg::LBA_W-1:0]       sd_lba,
	output logic                                    sd_rd,
	output logic                                    sd_wr,
	output logic                                    bk_busy,
	output logic                                    system_reset
);

	logic cart_dl;
	logic cheat_dl;
	logic clear_start;
	logic autoload_start;
	logic bk_enable;
	logic clearing;
	logic bk_loading;

	load_control u_load_control (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.ram_mask       (ram_mask),
		.clearing       (clearing),
		.bk_loading     (bk_loading),
		.cart_dl        (cart_dl),
		.cheat_dl       (cheat_dl),
		.clear_start    (clear_start),
		.autoload_start (autoload_start),
		.bk_enable      (bk_enable),
		.system_reset   (system_reset)
	);

	rom_header_parser u_rom_header_parser (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cart_dl         (cart_dl),
		.ioctl_addr      (ioctl_addr),
		.ioctl_dout      (ioctl_dout),
		.ioctl_wr        (ioctl_wr),
		.header_mode     (header_mode),
		.region_override (region_override),
		.rom_type        (rom_type),
		.rom_mask        (rom_mask),
		.ram_mask        (ram_mask),
		.pal             (pal)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cheat_dl     (cheat_dl),
		.cart_dl      (cart_dl),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.ioctl_wr     (ioctl_wr),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe),
		.cheat_reset  (cheat_reset)
	);

	wram_clear_engine #(
		.WRAM_AW (WRAM_AW)
	) u_wram_clear_engine (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.clear_start    (clear_start),
		.wram_init_mode (wram_init_mode),
		.wram_fill_addr (wram_fill_addr),
		.wram_fill_data (wram_fill_data),
		.wram_fill_wr   (wram_fill_wr),
		.clearing       (clearing)
	);

	backup_sequencer u_backup_sequencer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.bk_enable      (bk_enable),
		.bk_load_req    (bk_load_req),
		.bk_save_req    (bk_save_req),
		.autoload_start (autoload_start),
		.ram_mask       (ram_mask),
		.sd_ack         (sd_ack),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.bk_busy        (bk_busy),
		.bk_loading     (bk_loading)
	);

endmodule

/* tests/loader_checker.sv */
// Loader response checker
`timescale 1ns/1ps

module loader_checker #(
	parameter int AW = 8
) (
	input logic                                  clk_sys,
	input logic                                  reset,
	input logic [1:0]                            wram_init_mode,
	input logic [AW-1:0]                         wram_fill_addr,
	input logic [7:0]                            wram_fill_data,
	input logic                                  wram_fill_wr,
	input logic                                  system_reset,
	input logic                                  cheat_strobe,
	input logic                                  cheat_reset,
	input logic [snes_loader_pkg::LBA_W-1:0]     sd_lba,
	input logic                                  sd_rd,
	input logic                                  sd_wr
);

	int errors;
	int fill_count;
	int seen [2**AW];
	int strobe_count;
	int reset_count;
	int lba_q [$];
	bit dir_q [$];
	logic prev_rd;
	logic prev_wr;

	// Power-on fill rule per init mode
	function automatic logic [7:0] expected_fill(input logic [1:0] mode, input logic [9:0] a);
		case (mode)
			2'd0:    expected_fill = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1:    expected_fill = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2:    expected_fill = 8'h55;
			default: expected_fill = 8'hFF;
		endcase
	endfunction

	task automatic expect_hex(input string name, input logic [127:0] exp, input logic [127:0] act);
		if (exp !== act) begin
			$display("mismatch %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	task automatic begin_test();
		fill_count   = 0;
		strobe_count = 0;
		reset_count  = 0;
		lba_q.delete();
		dir_q.delete();
		for (int i = 0; i < 2**AW; i++) begin
			seen[i] = 0;
		end
	endtask

	task automatic check_fill();
		expect_hex("fill_count", 128'(2**AW), 128'(fill_count));
		for (int i = 0; i < 2**AW; i++) begin
			if (seen[i] != 1) begin
				$display("fill address %0h written %0d times", i, seen[i]);
				errors++;
			end
		end
	endtask

	task automatic check_cheat();
		expect_hex("cheat_strobe_count", 128'd1, 128'(strobe_count));
		expect_hex("cheat_reset_count", 128'd1, 128'(reset_count));
	endtask

	// Sectors must run 0 upward in one direction
	task automatic check_sectors(input bit is_write, input int n);
		expect_hex("sector_count", 128'(n), 128'(lba_q.size()));
		for (int i = 0; i < lba_q.size() && i < n; i++) begin
			expect_hex("sd_lba", 128'(i), 128'(lba_q[i]));
			expect_hex("sd_wr", 128'(is_write), 128'(dir_q[i]));
		end
	endtask

	// ==============================
	// Port monitors
	// ==============================
	always @(posedge clk_sys) begin
		if (reset) begin
			prev_rd <= 1'b0;
			prev_wr <= 1'b0;
		end else begin
			if (wram_fill_wr) begin
				fill_count++;
				seen[wram_fill_addr]++;
				expect_hex("wram_fill_data",
					128'(expected_fill(wram_init_mode, 10'(wram_fill_addr))),
					128'(wram_fill_data));
				if (!system_reset) begin
					note_failure("system reset dropped while work RAM was clearing");
				end
			end
			if (cheat_strobe) begin
				strobe_count++;
			end
			if (cheat_reset) begin
				reset_count++;
			end
			if ((sd_rd && !prev_rd) || (sd_wr && !prev_wr)) begin
				lba_q.push_back(int'(sd_lba));
				dir_q.push_back(sd_wr);
			end
			prev_rd <= sd_rd;
			prev_wr <= sd_wr;
		end
	end

endmodule

/* tests/tb_snes_loader.sv */
// Cartridge loader testbench
`timescale 1ns/1ps

module tb_snes_loader;

	localparam int AW    = 8;
	localparam int NROWS = 7;

	logic                                     clk_sys;
	logic                                     reset;
	logic                                     ioctl_download;
	logic [7:0]                               ioctl_index;
	logic [snes_loader_pkg::IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [snes_loader_pkg::IOCTL_DATA_W-1:0] ioctl_dout;
	logic                                     ioctl_wr;
	logic [2:0]                               header_mode;
	logic [1:0]                               region_override;
	logic [1:0]                               wram_init_mode;
	logic                                     img_mounted;
	logic                                     img_readonly;
	logic [63:0]                              img_size;
	logic                                     bk_load_req;
	logic                                     bk_save_req;
	logic                                     sd_ack;
	logic [7:0]                               rom_type;
	logic [snes_loader_pkg::MASK_W-1:0]       rom_mask;
	logic [snes_loader_pkg::MASK_W-1:0]       ram_mask;
	logic                                     pal;
	snes_loader_pkg::cheat_code_u             cheat_code;
	logic                                     cheat_strobe;
	logic                                     cheat_reset;
	logic [AW-1:0]                            wram_fill_addr;
	logic [7:0]                               wram_fill_data;
	logic                                     wram_fill_wr;
	logic [snes_loader_pkg::LBA_W-1:0]        sd_lba;
	logic                                     sd_rd;
	logic                                     sd_wr;
	logic                                     bk_busy;
	logic                                     system_reset;

	// Stimulus table, one entry per test
	string       row_name [NROWS];
	logic [2:0]  row_hdr [NROWS];
	logic [1:0]  row_rgn [NROWS];
	logic [1:0]  row_init [NROWS];
	int          row_kind [NROWS];
	int          row_nw [NROWS];
	logic [24:0] row_addr [NROWS][4];
	logic [15:0] row_data [NROWS][4];
	logic [23:0] row_rom_mask [NROWS];
	logic [23:0] row_ram_mask [NROWS];
	logic [7:0]  row_type [NROWS];
	logic        row_pal [NROWS];
	int          n_rows;

	// Words of the download in flight
	logic [24:0] dl_addr [8];
	logic [15:0] dl_data [8];
	int          dl_count;

	int          failed_tests;

	snes_loader_top #(
		.WRAM_AW (AW)
	) u_dut (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_wr, .header_mode, .region_override, .wram_init_mode, .img_mounted,
		.img_readonly, .img_size, .bk_load_req, .bk_save_req, .sd_ack, .rom_type,
		.rom_mask, .ram_mask, .pal, .cheat_code, .cheat_strobe, .cheat_reset,
		.wram_fill_addr, .wram_fill_data, .wram_fill_wr, .sd_lba, .sd_rd, .sd_wr,
		.bk_busy, .system_reset
	);

	loader_checker #(
		.AW (AW)
	) u_chk (
		.clk_sys, .reset, .wram_init_mode, .wram_fill_addr, .wram_fill_data,
		.wram_fill_wr, .system_reset, .cheat_strobe, .cheat_reset, .sd_lba,
		.sd_rd, .sd_wr
	);

	always #20 clk_sys = ~clk_sys;

	// Host side of the block interface
	initial begin
		int delay;
		forever begin
			@(posedge clk_sys);
			#1;
			if (sd_rd || sd_wr) begin
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge clk_sys);
				#2 sd_ack = 1'b1;
				@(posedge clk_sys);
				#2 sd_ack = 1'b0;
			end
		end
	end

	task automatic add_row(input string name, input logic [2:0] hdr, input logic [1:0] rgn,
		input logic [1:0] init, input int kind, input int nw,
		input logic [24:0] a0, input logic [15:0] d0, input logic [24:0] a1,
		input logic [15:0] d1, input logic [24:0] a2, input logic [15:0] d2,
		input logic [24:0] a3, input logic [15:0] d3, input logic [23:0] rom_m,
		input logic [23:0] ram_m, input logic [7:0] typ, input logic p);
		row_name[n_rows] = name;
		row_hdr[n_rows]  = hdr;
		row_rgn[n_rows]  = rgn;
		row_init[n_rows] = init;
		row_kind[n_rows] = kind;
		row_nw[n_rows]   = nw;
		row_addr[n_rows][0] = a0;
		row_data[n_rows][0] = d0;
		row_addr[n_rows][1] = a1;
		row_data[n_rows][1] = d1;
		row_addr[n_rows][2] = a2;
		row_data[n_rows][2] = d2;
		row_addr[n_rows][3] = a3;
		row_data[n_rows][3] = d3;
		row_rom_mask[n_rows] = rom_m;
		row_ram_mask[n_rows] = ram_m;
		row_type[n_rows]     = typ;
		row_pal[n_rows]      = p;
		n_rows++;
	endtask

	// ==============================
	// Test table
	// ==============================
	// Kinds are 0 cart, 1 cheat, 2 cart with backup, 3 cart without image
	task automatic build_table();
		n_rows = 0;
		// Sizes B and 3 from the first byte
		add_row("auto_sizes", 3'd0, 2'd0, 2'd0, 0, 2, 25'h0, 16'h213B, 25'h2, 16'h0100,
			25'h0, 16'h0, 25'h0, 16'h0, 24'h1FFFFF, 24'h001FFF, 8'h21, 1'b1);
		add_row("auto_default", 3'd0, 2'd1, 2'd1, 0, 1, 25'h0, 16'h4500, 25'h0, 16'h0,
			25'h0, 16'h0, 25'h0, 16'h0, 24'h3FFFFF, 24'h000000, 8'h45, 1'b0);
		add_row("lorom_forced", 3'd2, 2'd3, 2'd2, 0, 4, 25'h0, 16'hFFFF, 25'h2, 16'h0000,
			25'h81D6, 16'h0A00, 25'h81D8, 16'h0005, 24'h0FFFFF, 24'h007FFF, 8'h00, 1'b1);
		add_row("hirom_forced", 3'd3, 2'd0, 2'd3, 0, 4, 25'h0, 16'h0000, 25'h2, 16'h0100,
			25'h101D6, 16'h0900, 25'h101D8, 16'h0001, 24'h07FFFF, 24'h0007FF, 8'h01, 1'b1);
		add_row("cheat_code", 3'd0, 2'd0, 2'd0, 1, 8, 25'h0, 16'h0, 25'h0, 16'h0,
			25'h0, 16'h0, 25'h0, 16'h0, 24'h0, 24'h0, 8'h00, 1'b0);
		add_row("backup_save_load", 3'd0, 2'd0, 2'd0, 2, 2, 25'h0, 16'h001C, 25'h2, 16'h0000,
			25'h0, 16'h0, 25'h0, 16'h0, 24'h3FFFFF, 24'h0007FF, 8'h00, 1'b0);
		add_row("no_image", 3'd0, 2'd0, 2'd1, 3, 2, 25'h0, 16'h001C, 25'h2, 16'h0000,
			25'h0, 16'h0, 25'h0, 16'h0, 24'h3FFFFF, 24'h0007FF, 8'h00, 1'b0);
	endtask

	task automatic send_download(input logic [7:0] index);
		@(posedge clk_sys);
		#2;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		for (int i = 0; i < dl_count; i++) begin
			@(posedge clk_sys);
			#2;
			ioctl_addr = dl_addr[i];
			ioctl_dout = dl_data[i];
			ioctl_wr   = 1'b1;
			@(posedge clk_sys);
			#2 ioctl_wr = 1'b0;
		end
		@(posedge clk_sys);
		#2 ioctl_download = 1'b0;
	endtask

	task automatic pulse_save_request();
		@(posedge clk_sys);
		#2 bk_save_req = 1'b1;
		@(posedge clk_sys);
		#2 bk_save_req = 1'b0;
	endtask

	task automatic wait_busy_rise();
		int cnt;
		cnt = 0;
		while (cnt < 100 && !bk_busy) begin
			@(posedge clk_sys);
			#1 cnt++;
		end
		if (!bk_busy) begin
			u_chk.note_failure("timeout waiting for the backup sequencer to start");
		end
	endtask

	task automatic wait_loader_idle();
		int cnt;
		cnt = 0;
		while (cnt < 3000 && (wram_fill_wr || bk_busy || system_reset)) begin
			@(posedge clk_sys);
			#1 cnt++;
		end
		if (wram_fill_wr || bk_busy || system_reset) begin
			u_chk.note_failure("timeout waiting for the loader to go idle");
		end
		// pal settles once the download level is low
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	task automatic run_row(input int r);
		int errs_before;
		errs_before = u_chk.errors;
		u_chk.begin_test();
		@(posedge clk_sys);
		#2;
		header_mode     = row_hdr[r];
		region_override = row_rgn[r];
		wram_init_mode  = row_init[r];
		img_mounted     = (row_kind[r] == 2);
		dl_count        = row_nw[r];
		if (row_kind[r] == 1) begin
			for (int i = 0; i < 8; i++) begin
				dl_addr[i] = 25'(2 * i);
				dl_data[i] = 16'($urandom);
			end
			send_download(8'hFF);
			repeat (2) @(posedge clk_sys);
			#1;
			u_chk.check_cheat();
			u_chk.expect_hex("flags", {96'd0, dl_data[1], dl_data[0]},
				128'(cheat_code.fields.flags));
			u_chk.expect_hex("address", {96'd0, dl_data[3], dl_data[2]},
				128'(cheat_code.fields.address));
			u_chk.expect_hex("compare", {96'd0, dl_data[5], dl_data[4]},
				128'(cheat_code.fields.compare));
			u_chk.expect_hex("replace", {96'd0, dl_data[7], dl_data[6]},
				128'(cheat_code.fields.replace));
		end else begin
			for (int i = 0; i < dl_count; i++) begin
				dl_addr[i] = row_addr[r][i];
				dl_data[i] = row_data[r][i];
			end
			send_download(8'h00);
			wait_loader_idle();
			u_chk.check_fill();
			u_chk.expect_hex("rom_mask", 128'(row_rom_mask[r]), 128'(rom_mask));
			u_chk.expect_hex("ram_mask", 128'(row_ram_mask[r]), 128'(ram_mask));
			u_chk.expect_hex("rom_type", 128'(row_type[r]), 128'(rom_type));
			u_chk.expect_hex("pal", 128'(row_pal[r]), 128'(pal));
			if (row_kind[r] == 2) begin
				// Autoload reads every sector covered by ram_mask
				u_chk.check_sectors(1'b0, int'(row_ram_mask[r] / 512) + 1);
				u_chk.begin_test();
				pulse_save_request();
				wait_busy_rise();
				wait_loader_idle();
				u_chk.check_sectors(1'b1, int'(row_ram_mask[r] / 512) + 1);
			end else if (row_kind[r] == 3) begin
				pulse_save_request();
				repeat (40) @(posedge clk_sys);
				#1;
				u_chk.check_sectors(1'b1, 0);
				u_chk.expect_hex("bk_busy", 128'd0, 128'(bk_busy));
			end
		end
		if (u_chk.errors == errs_before) begin
			$display("test %s: ok", row_name[r]);
		end else begin
			$display("test %s: failed", row_name[r]);
			failed_tests++;
		end
	endtask

	initial begin
		void'($urandom(60516));
		clk_sys         = 1'b0;
		reset           = 1'b1;
		ioctl_download  = 1'b0;
		ioctl_index     = 8'h00;
		ioctl_addr      = '0;
		ioctl_dout      = '0;
		ioctl_wr        = 1'b0;
		header_mode     = 3'd0;
		region_override = 2'd0;
		wram_init_mode  = 2'd0;
		img_mounted     = 1'b0;
		img_readonly    = 1'b0;
		img_size        = 64'h800;
		bk_load_req     = 1'b0;
		bk_save_req     = 1'b0;
		sd_ack          = 1'b0;
		failed_tests    = 0;
		build_table();
		repeat (5) @(posedge clk_sys);
		#2 reset = 1'b0;
		for (int r = 0; r < n_rows; r++) begin
			run_row(r);
		end
		$display("tests %0d passed %0d failed %0d failed checks %0d",
			n_rows, n_rows - failed_tests, failed_tests, u_chk.errors);
		if (u_chk.errors == 0 && failed_tests == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* snes_loader_top.f */
hdl/snes_loader_pkg.sv
hdl/load_control.sv
hdl/rom_header_parser.sv
hdl/cheat_code_assembler.sv
hdl/wram_clear_engine.sv
hdl/backup_sequencer.sv
hdl/snes_loader_top.sv
tests/loader_checker.sv
tests/tb_snes_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_snes_loader \
	-f snes_loader_top.f -o sim_snes_loader

./obj_dir/sim_snes_loader | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1
